// ==== hw/alu_unit.sv ====
// Single-cycle integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic  clk,
    input  wire logic  rst_n,
    unit_issue_if.unit issue,
    unit_wb_if.source  wb
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic [XLEN-1:0] result;

    assign shamt = issue.b[4:0];

    always_comb begin
        case (issue.op)
            OP_ADD: result = issue.a + issue.b;
            OP_SUB: result = issue.a - issue.b;
            OP_SLL: result = issue.a << shamt;
            OP_SLT: result = XLEN'($signed(issue.a) < $signed(issue.b));
            OP_SLTU: result = XLEN'(issue.a < issue.b);
            OP_XOR: result = issue.a ^ issue.b;
            OP_SRL: result = issue.a >> shamt;
            OP_SRA: result = XLEN'($signed(issue.a) >>> shamt);
            OP_OR: result = issue.a | issue.b;
            OP_AND: result = issue.a & issue.b;
            OP_PASS_B: result = issue.b;
            default: result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            wb.data <= result;
            wb.id <= issue.id;
            wb.rd <= issue.rd;
        end
    end

    a_no_mul: assert property (@(posedge clk) disable iff (!rst_n)
        issue.valid |-> !is_mul_op(issue.op));

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
// Core-wide widths and types
`default_nettype none

package core_pkg;

    //////////////////////////////////////////////////
    // Widths
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ID_W = 3;

    // Issue ID that wraps after 2**ID_W operations
    typedef logic [ID_W-1:0] id_t;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //////////////////////////////////////////////////
    // Operations
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        // Passes operand b through for LUI
        OP_PASS_B,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU
    } core_op_t;

    // True for operations handled by the multiplier
    function automatic logic is_mul_op(core_op_t op);
        logic result;
        result = op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== hw/decode_issue.sv ====
// Decode and issue
`timescale 1ns/1ps
`default_nettype none

module decode_issue #(
    parameter int MUL_LATENCY = 3
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          instr_valid,
    input  wire logic [31:0]                   instr,
    output logic                               instr_ready,
    output logic                               illegal_instr,
    output core_pkg::reg_addr_t                rs1_addr,
    output core_pkg::reg_addr_t                rs2_addr,
    input  wire logic [core_pkg::XLEN-1:0]     rs1_data,
    input  wire logic [core_pkg::XLEN-1:0]     rs2_data,
    input  wire logic                          wb_valid,
    input  core_pkg::reg_addr_t                wb_rd,
    unit_issue_if.issuer                       alu_issue,
    unit_issue_if.issuer                       mul_issue
);
    import core_pkg::*;

    localparam int NUM_REGS = 2**REG_ADDR_W;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd_field;
    core_op_t op;
    logic legal, uses_rs1, uses_rs2, op_is_mul;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] operand_b;
    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] set_mask;
    logic [NUM_REGS-1:0] clr_mask;
    // Bit i set when a multiply was accepted i + 1 edges ago
    logic [MUL_LATENCY-1:0] mul_hist;
    logic hazard, discard, accept, issue_any;
    id_t next_id;
    core_op_t issue_op;
    logic [XLEN-1:0] issue_a;
    logic [XLEN-1:0] issue_b;
    id_t issue_id;
    reg_addr_t issue_rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd_field = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    //////////////////////////////////////////////////
    // Decode
    always_comb begin
        op = OP_ADD;
        legal = 1'b1;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm = {{(XLEN-12){instr[31]}}, instr[31:20]};
        case (opcode)
            OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: op = OP_ADD;
                    {F7_ALT, 3'b000}: op = OP_SUB;
                    {F7_BASE, 3'b001}: op = OP_SLL;
                    {F7_BASE, 3'b010}: op = OP_SLT;
                    {F7_BASE, 3'b011}: op = OP_SLTU;
                    {F7_BASE, 3'b100}: op = OP_XOR;
                    {F7_BASE, 3'b101}: op = OP_SRL;
                    {F7_ALT, 3'b101}: op = OP_SRA;
                    {F7_BASE, 3'b110}: op = OP_OR;
                    {F7_BASE, 3'b111}: op = OP_AND;
                    {F7_MULDIV, 3'b000}: op = OP_MUL;
                    {F7_MULDIV, 3'b001}: op = OP_MULH;
                    {F7_MULDIV, 3'b010}: op = OP_MULHSU;
                    {F7_MULDIV, 3'b011}: op = OP_MULHU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                case (funct3)
                    3'b000: op = OP_ADD;
                    3'b010: op = OP_SLT;
                    3'b011: op = OP_SLTU;
                    3'b100: op = OP_XOR;
                    3'b110: op = OP_OR;
                    3'b111: op = OP_AND;
                    3'b001: begin
                        op = OP_SLL;
                        legal = (funct7 == F7_BASE);
                        imm = {{(XLEN-5){1'b0}}, instr[24:20]};
                    end
                    default: begin
                        op = (funct7 == F7_ALT) ? OP_SRA : OP_SRL;
                        legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                        imm = {{(XLEN-5){1'b0}}, instr[24:20]};
                    end
                endcase
            end
            OPC_LUI: begin
                op = OP_PASS_B;
                imm = {instr[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    assign op_is_mul = is_mul_op(op);
    assign operand_b = uses_rs2 ? rs2_data : imm;

    //////////////////////////////////////////////////
    // Hazards and acceptance
    // An ALU result would collide with a multiply accepted MUL_LATENCY - 1 edges earlier
    assign hazard = (uses_rs1 && pending[rs1_addr]) || (uses_rs2 && pending[rs2_addr])
                    || pending[rd_field] || (!op_is_mul && mul_hist[MUL_LATENCY-2]);
    assign discard = (rd_field == '0);
    assign instr_ready = !legal || discard || !hazard;
    assign accept = instr_valid && instr_ready;
    assign issue_any = accept && legal && !discard;

    assign set_mask = issue_any ? (NUM_REGS'(1) << rd_field) : '0;
    assign clr_mask = wb_valid ? (NUM_REGS'(1) << wb_rd) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
            mul_hist <= '0;
            next_id <= '0;
            illegal_instr <= 1'b0;
            alu_issue.valid <= 1'b0;
            mul_issue.valid <= 1'b0;
        end else begin
            // Set wins over a same-edge clear
            pending <= (pending & ~clr_mask) | set_mask;
            mul_hist <= {mul_hist[MUL_LATENCY-2:0], issue_any && op_is_mul};
            next_id <= issue_any ? id_t'(next_id + 1'b1) : next_id;
            illegal_instr <= accept && !legal;
            alu_issue.valid <= issue_any && !op_is_mul;
            mul_issue.valid <= issue_any && op_is_mul;
        end
    end

    // Issue packet shared by both units
    always_ff @(posedge clk) begin
        if (issue_any) begin
            issue_op <= op;
            issue_a <= rs1_data;
            issue_b <= operand_b;
            issue_id <= next_id;
            issue_rd <= rd_field;
        end
    end

    assign alu_issue.op = issue_op;
    assign alu_issue.a = issue_a;
    assign alu_issue.b = issue_b;
    assign alu_issue.id = issue_id;
    assign alu_issue.rd = issue_rd;
    assign mul_issue.op = issue_op;
    assign mul_issue.a = issue_a;
    assign mul_issue.b = issue_b;
    assign mul_issue.id = issue_id;
    assign mul_issue.rd = issue_rd;

    //////////////////////////////////////////////////
    // Assertions
    // A second issue to a busy register would find it already cleared at its write
    a_wr_pending: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> pending[wb_rd]);

    a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_issue.valid && mul_issue.valid));

    // Multiplier result must land the cycle the history predicts
    a_mul_wb_slot: assert property (@(posedge clk) disable iff (!rst_n)
        mul_hist[MUL_LATENCY-1] |=> wb_valid);

endmodule

`default_nettype wire

// ==== hw/mini_core.sv ====
// Mini RV32IM execution core
`timescale 1ns/1ps
`default_nettype none

module mini_core #(
    parameter int MUL_LATENCY = 3
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          instr_valid,
    input  wire logic [31:0]                   instr,
    output logic                               instr_ready,
    output logic                               illegal_instr,
    output logic                               retire_valid,
    output core_pkg::id_t                      retire_id,
    output core_pkg::reg_addr_t                retire_rd,
    output logic [core_pkg::XLEN-1:0]          retire_data
);
    import core_pkg::*;

    reg_addr_t rs1_addr, rs2_addr, wr_addr;
    logic [XLEN-1:0] rs1_data, rs2_data, wr_data;
    logic wr_en;

    unit_issue_if alu_issue ();
    unit_issue_if mul_issue ();
    unit_wb_if alu_wb ();
    unit_wb_if mul_wb ();

    //////////////////////////////////////////////////
    // Decode and operands
    decode_issue #(.MUL_LATENCY(MUL_LATENCY)) i_decode_issue (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr(instr),
        .instr_ready(instr_ready), .illegal_instr(illegal_instr),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_valid(wr_en), .wb_rd(wr_addr),
        .alu_issue(alu_issue), .mul_issue(mul_issue)
    );

    register_file i_register_file (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    //////////////////////////////////////////////////
    // Execution units and writeback
    alu_unit i_alu_unit (.clk(clk), .rst_n(rst_n), .issue(alu_issue), .wb(alu_wb));

    mul_unit #(.MUL_LATENCY(MUL_LATENCY)) i_mul_unit (
        .clk(clk), .rst_n(rst_n), .issue(mul_issue), .wb(mul_wb)
    );

    writeback i_writeback (
        .clk(clk), .rst_n(rst_n),
        .alu_wb(alu_wb), .mul_wb(mul_wb),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .retire_valid(retire_valid), .retire_id(retire_id),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

endmodule

`default_nettype wire

// ==== hw/mul_unit.sv ====
// Pipelined signed/unsigned multiplier
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter int MUL_LATENCY = 3
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    unit_issue_if.unit issue,
    unit_wb_if.source  wb
);
    import core_pkg::*;

    logic signed [XLEN:0] a_ext;
    logic signed [XLEN:0] b_ext;
    logic signed [2*XLEN+1:0] product;
    logic [MUL_LATENCY-1:0] valid_q;
    logic [MUL_LATENCY-1:0] hi_q;
    logic [2*XLEN-1:0] prod_q [MUL_LATENCY];
    id_t id_q [MUL_LATENCY];
    reg_addr_t rd_q [MUL_LATENCY];

    // Operand a is signed for MULH and MULHSU, b only for MULH
    assign a_ext = {(issue.op inside {OP_MULH, OP_MULHSU}) & issue.a[XLEN-1], issue.a};
    assign b_ext = {(issue.op == OP_MULH) & issue.b[XLEN-1], issue.b};
    assign product = (2*XLEN+2)'(a_ext) * (2*XLEN+2)'(b_ext);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_LATENCY-2:0], issue.valid};
        end
    end

    //////////////////////////////////////////////////
    // Pipeline stages
    always_ff @(posedge clk) begin
        prod_q[0] <= product[2*XLEN-1:0];
        hi_q[0] <= (issue.op != OP_MUL);
        id_q[0] <= issue.id;
        rd_q[0] <= issue.rd;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            prod_q[i] <= prod_q[i-1];
            hi_q[i] <= hi_q[i-1];
            id_q[i] <= id_q[i-1];
            rd_q[i] <= rd_q[i-1];
        end
    end

    assign wb.valid = valid_q[MUL_LATENCY-1];
    assign wb.id = id_q[MUL_LATENCY-1];
    assign wb.rd = rd_q[MUL_LATENCY-1];
    assign wb.data = hi_q[MUL_LATENCY-1] ? prod_q[MUL_LATENCY-1][2*XLEN-1:XLEN]
                                         : prod_q[MUL_LATENCY-1][XLEN-1:0];

    a_only_mul: assert property (@(posedge clk) disable iff (!rst_n)
        issue.valid |-> is_mul_op(issue.op));

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  core_pkg::reg_addr_t                rs1_addr,
    input  core_pkg::reg_addr_t                rs2_addr,
    output logic [core_pkg::XLEN-1:0]          rs1_data,
    output logic [core_pkg::XLEN-1:0]          rs2_data,
    input  wire logic                          wr_en,
    input  core_pkg::reg_addr_t                wr_addr,
    input  wire logic [core_pkg::XLEN-1:0]     wr_data
);
    import core_pkg::*;

    localparam int NUM_REGS = 2**REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

// ==== hw/unit_issue_if.sv ====
// Issue path to an execution unit
`timescale 1ns/1ps
`default_nettype none

interface unit_issue_if;
    import core_pkg::*;

    // One-cycle strobe per issued operation
    logic valid;
    core_op_t op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    id_t id;
    reg_addr_t rd;

    modport issuer (
        output valid, op, a, b, id, rd
    );

    modport unit (
        input valid, op, a, b, id, rd
    );

endinterface

`default_nettype wire

// ==== hw/unit_wb_if.sv ====
// Unit result path to writeback
`timescale 1ns/1ps
`default_nettype none

interface unit_wb_if;
    import core_pkg::*;

    logic valid;
    id_t id;
    reg_addr_t rd;
    logic [XLEN-1:0] data;

    modport source (
        output valid, id, rd, data
    );

    modport sink (
        input valid, id, rd, data
    );

endinterface

`default_nettype wire

// ==== hw/writeback.sv ====
// Result merge and retire
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    unit_wb_if.sink                        alu_wb,
    unit_wb_if.sink                        mul_wb,
    output logic                           wr_en,
    output core_pkg::reg_addr_t            wr_addr,
    output logic [core_pkg::XLEN-1:0]      wr_data,
    output logic                           retire_valid,
    output core_pkg::id_t                  retire_id,
    output core_pkg::reg_addr_t            retire_rd,
    output logic [core_pkg::XLEN-1:0]      retire_data
);
    import core_pkg::*;

    id_t wr_id;

    // At most one unit presents a result per cycle
    assign wr_en = alu_wb.valid | mul_wb.valid;
    assign wr_addr = alu_wb.valid ? alu_wb.rd : mul_wb.rd;
    assign wr_data = alu_wb.valid ? alu_wb.data : mul_wb.data;
    assign wr_id = alu_wb.valid ? alu_wb.id : mul_wb.id;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        retire_id <= wr_id;
        retire_rd <= wr_addr;
        retire_data <= wr_data;
    end

    a_no_collision: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_wb.valid && mul_wb.valid));

endmodule

`default_nettype wire

// ==== list.f ====
hw/core_pkg.sv
hw/unit_issue_if.sv
hw/unit_wb_if.sv
hw/register_file.sv
hw/decode_issue.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/writeback.sv
hw/mini_core.sv
tb/tb_mini_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mini_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_mini_core --Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_mini_core" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tb/tb_mini_core.sv ====
// Testbench for the mini RV32IM core
`timescale 1ns/1ps
`default_nettype none

module tb_mini_core;

    localparam int MUL_LATENCY = 3;
    localparam int N_SEED = 14;
    localparam int N_RANDOM = 400;
    localparam int N_CHAIN = 80;
    localparam int N_BURSTS = 8;
    localparam int BURST_LEN = 6;
    localparam int TOTAL_INSTR = N_SEED + N_RANDOM + N_CHAIN + N_BURSTS * BURST_LEN;
    localparam int WATCHDOG_NS = TOTAL_INSTR * (MUL_LATENCY + 4) * 10 + 2000;

    // Encoder constants
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam int K_REG = 0;
    localparam int K_IMM = 1;
    localparam int K_LUI = 2;
    localparam int K_BAD = 3;

    logic clk;
    logic rst_n;
    logic instr_valid;
    logic [31:0] instr;
    logic instr_ready;
    logic illegal_instr;
    logic retire_valid;
    logic [2:0] retire_id;
    logic [4:0] retire_rd;
    logic [31:0] retire_data;

    // Reference model state written by the driver only
    logic [31:0] arch [32];
    logic [4:0] exp_rd [8];
    logic [31:0] exp_data [8];
    int issued_n [8];
    logic [2:0] next_id;
    logic illegal_due;
    int drv_errors;
    int issued_total;
    int illegal_total;

    // Written by the retire monitor only
    int retired_n [8];
    int mon_errors;

    // Instruction currently offered to the DUT
    int cur_kind;
    logic [2:0] cur_f3;
    logic [6:0] cur_f7;
    logic [4:0] cur_rd, cur_rs1, cur_rs2;
    logic [31:0] cur_imm;

    mini_core #(.MUL_LATENCY(MUL_LATENCY)) i_mini_core (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr(instr),
        .instr_ready(instr_ready), .illegal_instr(illegal_instr),
        .retire_valid(retire_valid), .retire_id(retire_id),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Reference arithmetic from the ISA rules
    function automatic logic [31:0] ref_result(int kind, logic [2:0] f3, logic [6:0] f7,
                                               logic [31:0] a, logic [31:0] b);
        logic [63:0] sa, ua, sb, ub;
        logic [63:0] prod;
        logic [31:0] res;
        sa = {{32{a[31]}}, a};
        ua = {32'b0, a};
        sb = {{32{b[31]}}, b};
        ub = {32'b0, b};
        res = '0;
        if (kind == K_LUI) begin
            res = b;
        end else if (kind == K_REG && f7 == 7'h01) begin
            case (f3[1:0])
                2'd1: prod = sa * sb;
                2'd2: prod = sa * ub;
                default: prod = ua * ub;
            endcase
            res = (f3[1:0] == 2'd0) ? prod[31:0] : prod[63:32];
        end else begin
            case (f3)
                3'd0: res = (kind == K_REG && f7 == 7'h20) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = {31'b0, $signed(a) < $signed(b)};
                3'd3: res = {31'b0, a < b};
                3'd4: res = a ^ b;
                3'd5: begin
                    if (f7 == 7'h20) begin
                        res = $signed(a) >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end
        return res;
    endfunction

    function automatic logic any_outstanding();
        logic busy;
        busy = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (issued_n[i] != retired_n[i]) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(7));
    endfunction

    // SUB and SRA variants half the time
    function automatic logic [6:0] alt_f7(logic [2:0] f3);
        logic [6:0] f7;
        f7 = 7'h00;
        if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1) == 1) begin
            f7 = 7'h20;
        end
        return f7;
    endfunction

    function automatic logic [19:0] pick_upper();
        logic [19:0] up;
        case ($urandom_range(4))
            0: up = 20'h80000;
            1: up = 20'hfffff;
            2: up = 20'h7ffff;
            3: up = 20'h00000;
            default: up = 20'($urandom());
        endcase
        return up;
    endfunction

    //////////////////////////////////////////////////
    // Driver
    // Called at each accepting edge in acceptance order
    task automatic update_model();
        logic [31:0] a, b, value;
        if (cur_kind == K_BAD) begin
            illegal_due = 1'b1;
            illegal_total++;
        end else if (cur_rd != 5'd0) begin
            a = arch[cur_rs1];
            b = (cur_kind == K_REG) ? arch[cur_rs2] : cur_imm;
            value = ref_result(cur_kind, cur_f3, cur_f7, a, b);
            if (issued_n[next_id] != retired_n[next_id]) begin
                $display("ID %0d handed out again before it retired", next_id);
                drv_errors++;
            end
            exp_rd[next_id] = cur_rd;
            exp_data[next_id] = value;
            issued_n[next_id]++;
            arch[cur_rd] = value;
            next_id = next_id + 3'd1;
            issued_total++;
        end
    endtask

    task automatic send_instr(logic [31:0] word);
        logic took;
        instr = word;
        instr_valid = 1'b1;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = instr_ready;
            // Illegal words and writes to x0 are always taken at once
            if (!took && (cur_kind == K_BAD || cur_rd == 5'd0)) begin
                $display("instr_ready is low for a word that must never stall");
                drv_errors++;
            end
            @(posedge clk);
            illegal_due = 1'b0;
            if (took) begin
                update_model();
            end
            #1;
        end
        instr_valid = 1'b0;
        instr = $urandom();
        if ($urandom_range(3) == 0) begin
            @(posedge clk);
            illegal_due = 1'b0;
            #1;
        end
    endtask

    task automatic do_reg(logic [2:0] f3, logic [6:0] f7, logic [4:0] rd,
                          logic [4:0] rs1, logic [4:0] rs2);
        cur_kind = K_REG;
        cur_f3 = f3;
        cur_f7 = f7;
        cur_rd = rd;
        cur_rs1 = rs1;
        cur_rs2 = rs2;
        cur_imm = '0;
        send_instr({f7, rs2, rs1, f3, rd, OPC_OP});
    endtask

    task automatic do_imm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        cur_kind = K_IMM;
        cur_f3 = f3;
        cur_f7 = imm[11:5];
        cur_rd = rd;
        cur_rs1 = rs1;
        cur_rs2 = 5'd0;
        cur_imm = {{20{imm[11]}}, imm};
        send_instr({imm, rs1, f3, rd, OPC_OP_IMM});
    endtask

    task automatic do_lui(logic [4:0] rd, logic [19:0] up);
        cur_kind = K_LUI;
        cur_f3 = 3'd0;
        cur_f7 = 7'd0;
        cur_rd = rd;
        cur_rs1 = 5'd0;
        cur_rs2 = 5'd0;
        cur_imm = {up, 12'b0};
        send_instr({up, rd, OPC_LUI});
    endtask

    // Load opcode, DIV/REM, bad OP funct7, SLLI with funct7 set
    task automatic do_illegal(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        logic [31:0] word;
        word = $urandom();
        case ($urandom_range(3))
            0: word[6:0] = 7'b0000011;
            1: word = {7'h01, rs2, rs1, 3'(4 + $urandom_range(3)), rd, OPC_OP};
            2: word = {7'h20, rs2, rs1, 3'd1, rd, OPC_OP};
            default: word = {7'h20, rs2, rs1, 3'd1, rd, OPC_OP_IMM};
        endcase
        cur_kind = K_BAD;
        send_instr(word);
    endtask

    task automatic do_random(logic [4:0] rd, logic [4:0] rs1);
        int sel;
        logic [2:0] f3;
        logic [4:0] rs2;
        logic [4:0] shamt;
        logic [11:0] imm;
        sel = $urandom_range(10);
        f3 = 3'($urandom());
        rs2 = rand_reg();
        shamt = 5'($urandom());
        if (sel < 4) begin
            do_reg(f3, alt_f7(f3), rd, rs1, rs2);
        end else if (sel < 7) begin
            if (f3 == 3'd1) begin
                imm = {7'b0, shamt};
            end else if (f3 == 3'd5) begin
                imm = {alt_f7(f3), shamt};
            end else begin
                imm = 12'($urandom());
            end
            do_imm(f3, rd, rs1, imm);
        end else if (sel == 7) begin
            do_lui(rd, pick_upper());
        end else if (sel < 10) begin
            do_reg(3'($urandom_range(3)), 7'h01, rd, rs1, rs2);
        end else begin
            do_illegal(rd, rs1, rs2);
        end
    endtask

    //////////////////////////////////////////////////
    // Retire and illegal pulse monitor
    always @(negedge clk) begin
        if (rst_n) begin
            if (illegal_instr !== illegal_due) begin
                $display("MISMATCH illegal_instr: got %h, expected %h",
                         illegal_instr, illegal_due);
                mon_errors++;
            end
            if (retire_valid && retired_n[retire_id] >= issued_n[retire_id]) begin
                $display("Retire for ID %0d, which is not outstanding", retire_id);
                mon_errors++;
            end else if (retire_valid) begin
                if (retire_rd !== exp_rd[retire_id] || retire_data !== exp_data[retire_id]) begin
                    $display("MISMATCH retire_id=%h retire_rd=%h (exp %h) retire_data=%h (exp %h)",
                             retire_id, retire_rd, exp_rd[retire_id],
                             retire_data, exp_data[retire_id]);
                    mon_errors++;
                end
                retired_n[retire_id]++;
            end
        end
    end

    // Watchdog sized from the instruction count
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Errors: %0d", drv_errors + mon_errors + 1);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        int wait_cycles;
        logic [4:0] prev_rd;
        logic [4:0] rd;
        void'($urandom(32'hff3597c1));
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        illegal_due = 1'b0;
        next_id = '0;
        drv_errors = 0;
        issued_total = 0;
        illegal_total = 0;
        for (int i = 0; i < 32; i++) begin
            arch[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Extreme operand values in x1..x7
        for (int r = 1; r < 8; r++) begin
            do_lui(5'(r), pick_upper());
            do_imm(3'd0, 5'(r), 5'(r), 12'($urandom()));
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            do_random(rand_reg(), rand_reg());
        end
        // Each op reads the previous destination
        prev_rd = 5'd1;
        for (int n = 0; n < N_CHAIN; n++) begin
            rd = 5'(1 + $urandom_range(6));
            do_random(rd, prev_rd);
            prev_rd = rd;
        end
        // Independent multiplies into x8..x13
        for (int b = 0; b < N_BURSTS; b++) begin
            for (int k = 0; k < BURST_LEN; k++) begin
                do_reg(3'($urandom_range(3)), 7'h01, 5'(8 + k), rand_reg(), rand_reg());
            end
        end

        wait_cycles = 0;
        while (any_outstanding() && wait_cycles < 10 * (MUL_LATENCY + 4)) begin
            @(posedge clk);
            illegal_due = 1'b0;
            wait_cycles++;
        end
        repeat (4) begin
            @(posedge clk);
            illegal_due = 1'b0;
        end
        if (any_outstanding()) begin
            $display("Some IDs never retired by the end of the run");
            drv_errors++;
        end
        $display("Errors: %0d (model %0d, monitor %0d), retiring instructions %0d, illegal %0d",
                 drv_errors + mon_errors, drv_errors, mon_errors, issued_total, illegal_total);
        if (drv_errors + mon_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
